// ==== coreSvc.f ====
+incdir+hdl
hdl/coreSvcPkg.sv
hdl/returnFifo.sv
hdl/returnArbiter.sv
hdl/tickGen.sv
hdl/intSequencer.sv
hdl/coreSvc.sv
tests/coreSvc_asserts.sv
tests/coreSvcTb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the coreSvc testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module coreSvcTb \
	-f coreSvc.f -Mdir obj_dir -o coreSvcSim

output=$(./obj_dir/coreSvcSim)
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -q "TESTBENCH PASSED"; then
	exit 0
fi
exit 1

// ==== tests/coreSvcTb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "coreSvc_cfg.svh"

module coreSvcTb;
	import coreSvcPkg::*;

	localparam int clkPeriod = 4;
	localparam int depth = `RETURN_FIFO_DEPTH;
	localparam int watchdogCycles = 2000;

	logic        EXTCLK;
	logic        rstN;
	logic        streamWr;
	logic        netWr;
	logic        localDrdy;
	logic        streamFull;
	logic        netFull;
	logic        localRd;
	logic        coreDrdy;
	logic        tickPulse;
	logic        coreStop;
	logic        msgIntReq;
	returnBeat_t streamWrBeat;
	returnBeat_t netWrBeat;
	returnBeat_t localBeat;
	returnBeat_t coreBeat;
	intCtrl_t    intCtrl;
	coreState_t  coreState;

	// reference model state, updated once per rising edge
	returnBeat_t netQ[$];
	returnBeat_t streamQ[$];
	returnBeat_t expBeat;
	logic        expDrdy;
	logic        expTick;
	logic        expMsg;
	logic        mPending;
	logic        mReqSent;
	logic        localTaken;
	int          tickCnt;

	int          errCount;
	int          checkCount;
	int          tickCount;
	int          msgCount;
	logic        msgInInterval;
	logic        sawStreamFull;
	logic        priorityPhase;
	logic        intRandom;
	logic [1:0]  lastRank;

	coreSvc u_coreSvc (.EXTCLK(EXTCLK), .rstN(rstN),
		.streamWr(streamWr), .streamWrBeat(streamWrBeat), .streamFull(streamFull),
		.netWr(netWr), .netWrBeat(netWrBeat), .netFull(netFull),
		.localDrdy(localDrdy), .localBeat(localBeat), .localRd(localRd),
		.coreDrdy(coreDrdy), .coreBeat(coreBeat), .tickPulse(tickPulse),
		.intCtrl(intCtrl), .coreState(coreState), .coreStop(coreStop), .msgIntReq(msgIntReq));

	always #(clkPeriod / 2) EXTCLK = ~EXTCLK;

	function automatic logic chance(input int tenths);
		return $urandom_range(9, 0) < tenths;
	endfunction

	// top two tag bits carry the source, 0 net, 1 stream, 2 local
	function automatic returnBeat_t makeBeat(input logic [1:0] src);
		returnBeat_t beat;
		beat.size = `SIZE_W'($urandom_range(7, 0));
		beat.tag = {src, (`TAG_W - 2)'($urandom)};
		beat.data = {$urandom, $urandom};
		return beat;
	endfunction

	task automatic checkBit(input string name, input logic actual, input logic expected);
		checkCount++;
		if (actual !== expected)
		begin
			errCount++;
			$display("ERR %s expected %h actual %h at %0t", name, expected, actual, $time);
		end
	endtask

	task automatic checkBeat(input string name, input returnBeat_t actual,
		input returnBeat_t expected);
		checkCount++;
		if (actual !== expected)
		begin
			errCount++;
			$display("ERR %s expected %h actual %h at %0t", name, expected, actual, $time);
		end
	endtask

	task automatic checkResetState;
		checkBit("coreDrdy", coreDrdy, 1'b0);
		checkBit("localRd", localRd, 1'b0);
		checkBit("tickPulse", tickPulse, 1'b0);
		checkBit("coreStop", coreStop, 1'b0);
		checkBit("msgIntReq", msgIntReq, 1'b0);
		checkBit("streamFull", streamFull, 1'b0);
		checkBit("netFull", netFull, 1'b0);
		checkBit("netRd", u_coreSvc.netRd, 1'b0);
		checkBit("streamRd", u_coreSvc.streamRd, 1'b0);
		checkBit("netEmpty", u_coreSvc.netEmpty, 1'b1);
		checkBit("streamEmpty", u_coreSvc.streamEmpty, 1'b1);
	endtask

	//===========================================================================
	// cycle model
	//===========================================================================
	task automatic modelStep;
		logic nFull;
		logic sFull;
		logic intPend;
		nFull = (netQ.size() == depth);
		sFull = (streamQ.size() == depth);
		localTaken = 1'b0;
		expDrdy = 1'b1;
		// network first, then stream, local last
		if (netQ.size() != 0)
			expBeat = netQ.pop_front();
		else if (streamQ.size() != 0)
			expBeat = streamQ.pop_front();
		else if (localDrdy)
		begin
			expBeat = localBeat;
			localTaken = 1'b1;
		end
		else
			expDrdy = 1'b0;
		if (netWr && !nFull)
			netQ.push_back(netWrBeat);
		if (streamWr && !sFull)
			streamQ.push_back(streamWrBeat);
		expTick = (tickCnt == `TICK_SCALE - 1);
		tickCnt = expTick ? 0 : tickCnt + 1;
		// pending as seen before the edge, gone at once while ena is low
		intPend = mPending && intCtrl.ena;
		expMsg = intPend && coreState.empty && !coreState.bkpt && !mReqSent;
		// one request per pending interval
		if (!intPend)
			mReqSent = 1'b0;
		else if (expMsg)
			mReqSent = 1'b1;
		// ack or ena low clears on the edge, req sets
		if (!intCtrl.ena || intCtrl.ack)
			mPending = 1'b0;
		else if (intCtrl.req)
			mPending = 1'b1;
	endtask

	task automatic checkOutputs;
		logic [1:0] rank;
		checkBit("coreDrdy", coreDrdy, expDrdy);
		if (expDrdy)
			checkBeat("coreBeat", coreBeat, expBeat);
		checkBit("localRd", localRd, netQ.size() == 0 && streamQ.size() == 0 && localDrdy);
		checkBit("tickPulse", tickPulse, expTick);
		checkBit("coreStop", coreStop, mPending && intCtrl.ena);
		checkBit("msgIntReq", msgIntReq, expMsg);
		checkBit("streamFull", streamFull, streamQ.size() == depth);
		checkBit("netFull", netFull, netQ.size() == depth);
		if (tickPulse)
			tickCount++;
		if (msgIntReq)
		begin
			msgCount++;
			if (msgInInterval)
			begin
				errCount++;
				$display("second msgIntReq within one pending interval at %0t", $time);
			end
			msgInInterval = 1'b1;
		end
		if (!coreStop)
			msgInInterval = 1'b0;
		if (streamFull)
			sawStreamFull = 1'b1;
		if (priorityPhase && coreDrdy)
		begin
			rank = coreBeat.tag[`TAG_W-1 -: 2];
			if (rank < lastRank)
			begin
				errCount++;
				$display("priority broken, source %0d beat left after source %0d", rank, lastRank);
			end
			lastRank = rank;
		end
	endtask

	// drive on the falling edge, advance the model, check at the next falling edge
	task automatic runCycle(input logic wantStream, input logic wantNet, input logic wantLocal);
		streamWr = wantStream && (streamQ.size() < depth);
		if (streamWr)
			streamWrBeat = makeBeat(2'd1);
		netWr = wantNet && (netQ.size() < depth);
		if (netWr)
			netWrBeat = makeBeat(2'd0);
		// a local beat stays offered until taken
		if (!(localDrdy && !localTaken))
		begin
			localDrdy = wantLocal;
			if (wantLocal)
				localBeat = makeBeat(2'd2);
		end
		if (intRandom)
		begin
			intCtrl = '{req: chance(2), ena: chance(9), ack: chance(1)};
			coreState = '{empty: chance(6), bkpt: chance(2)};
		end
		modelStep();
		@(negedge EXTCLK);
		checkOutputs();
	endtask

	task automatic drainAll;
		int guard;
		guard = 0;
		while ((netQ.size() != 0 || streamQ.size() != 0 || (localDrdy && !localTaken))
			&& guard < 64)
		begin
			runCycle(1'b0, 1'b0, 1'b0);
			guard++;
		end
		if (guard == 64)
		begin
			errCount++;
			$display("return queues did not drain within 64 cycles");
		end
	endtask

	//===========================================================================
	// stimulus
	//===========================================================================
	initial
	begin
		void'($urandom(32'hc0e));
		EXTCLK = 1'b0;
		rstN = 1'b0;
		{streamWr, netWr, localDrdy} = '0;
		{streamWrBeat, netWrBeat, localBeat} = '0;
		intCtrl = '0;
		coreState = '0;
		{expDrdy, expTick, expMsg, mPending, mReqSent, localTaken} = '0;
		expBeat = '0;
		{tickCnt, errCount, checkCount, tickCount, msgCount} = '0;
		{sawStreamFull, priorityPhase, intRandom, msgInInterval} = '0;
		lastRank = '0;
		repeat (4)
		begin
			@(negedge EXTCLK);
			checkResetState();
		end
		rstN = 1'b1;
		repeat (5)
			runCycle(1'b0, 1'b0, 1'b0);
		intRandom = 1'b1;
		repeat (600)
			runCycle(chance(4), chance(4), chance(5));
		drainAll();
		// all three sources hold data together from the second cycle on
		priorityPhase = 1'b1;
		runCycle(1'b1, 1'b1, 1'b0);
		repeat (5)
			runCycle(1'b1, 1'b1, 1'b1);
		drainAll();
		priorityPhase = 1'b0;
		// network traffic keeps the arbiter away from the stream FIFO
		runCycle(1'b0, 1'b1, 1'b0);
		repeat (16)
			runCycle(1'b1, 1'b1, 1'b0);
		repeat (2)
			runCycle(1'b0, 1'b1, 1'b0);
		drainAll();
		repeat (150)
			runCycle(1'b0, 1'b0, 1'b0);
		if (tickCount < 10)
		begin
			errCount++;
			$display("only %0d tick pulses seen, at least ten expected", tickCount);
		end
		if (!sawStreamFull)
		begin
			errCount++;
			$display("stream FIFO never reported full");
		end
		if (msgCount == 0)
		begin
			errCount++;
			$display("no message request seen during interrupt traffic");
		end
		$display("checks %0d errors %0d ticks %0d msgIntReq %0d",
			checkCount, errCount, tickCount, msgCount);
		if (errCount == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

	initial
	begin
		#(watchdogCycles * clkPeriod);
		$display("watchdog expired after %0d cycles, run did not complete", watchdogCycles);
		$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== tests/coreSvc_asserts.sv ====
`timescale 1ns/1ps
`default_nettype none

module coreSvc_asserts (
	input logic                 EXTCLK,
	input logic                 rstN,
	input logic                 netEmpty,
	input logic                 streamEmpty,
	input logic                 netRd,
	input logic                 streamRd,
	input logic                 localRd,
	input coreSvcPkg::intCtrl_t intCtrl,
	input logic                 coreStop,
	input logic                 msgIntReq
);

	oneGrant: assert property (@(posedge EXTCLK) disable iff (!rstN)
		$onehot0({netRd, streamRd, localRd}))
		else $error("more than one read strobe in one cycle");

	noEmptyRead: assert property (@(posedge EXTCLK) disable iff (!rstN)
		!(netRd && netEmpty) && !(streamRd && streamEmpty))
		else $error("read strobe raised on an empty FIFO");

	msgOneCycle: assert property (@(posedge EXTCLK) disable iff (!rstN)
		msgIntReq |=> !msgIntReq)
		else $error("msgIntReq held longer than one cycle");

	stopNeedsEna: assert property (@(posedge EXTCLK) disable iff (!rstN)
		!intCtrl.ena |-> !coreStop)
		else $error("coreStop high while interrupts are disabled");

endmodule

// ports a target lacks are tied to idle values
bind returnArbiter coreSvc_asserts arbChecks (.EXTCLK(EXTCLK), .rstN(rstN),
	.netEmpty(netEmpty), .streamEmpty(streamEmpty), .netRd(netRd), .streamRd(streamRd),
	.localRd(localRd), .intCtrl('0), .coreStop(1'b0), .msgIntReq(1'b0));

bind intSequencer coreSvc_asserts seqChecks (.EXTCLK(EXTCLK), .rstN(rstN),
	.netEmpty(1'b1), .streamEmpty(1'b1), .netRd(1'b0), .streamRd(1'b0),
	.localRd(1'b0), .intCtrl(intCtrl), .coreStop(coreStop), .msgIntReq(msgIntReq));

`default_nettype wire

// ==== hdl/coreSvc.sv ====
`timescale 1ns/1ps
`default_nettype none

module coreSvc (
	input  logic                    EXTCLK,
	input  logic                    rstN,
	// stream return channel
	input  logic                    streamWr,
	input  coreSvcPkg::returnBeat_t streamWrBeat,
	output logic                    streamFull,
	// network return channel
	input  logic                    netWr,
	input  coreSvcPkg::returnBeat_t netWrBeat,
	output logic                    netFull,
	// local memory channel
	input  logic                    localDrdy,
	input  coreSvcPkg::returnBeat_t localBeat,
	output logic                    localRd,
	// return data to the core
	output logic                    coreDrdy,
	output coreSvcPkg::returnBeat_t coreBeat,
	output logic                    tickPulse,
	// interrupt control
	input  coreSvcPkg::intCtrl_t    intCtrl,
	input  coreSvcPkg::coreState_t  coreState,
	output logic                    coreStop,
	output logic                    msgIntReq
);
	import coreSvcPkg::*;

	returnBeat_t streamBeat;
	returnBeat_t netBeat;
	logic        streamEmpty;
	logic        netEmpty;
	logic        streamRd;
	logic        netRd;

	//==========================================================================
	// return data path
	//==========================================================================
	returnFifo streamFifo (.EXTCLK(EXTCLK), .rstN(rstN), .wr(streamWr), .wrBeat(streamWrBeat),
		.rd(streamRd), .rdBeat(streamBeat), .empty(streamEmpty), .full(streamFull));

	returnFifo netFifo (.EXTCLK(EXTCLK), .rstN(rstN), .wr(netWr), .wrBeat(netWrBeat),
		.rd(netRd), .rdBeat(netBeat), .empty(netEmpty), .full(netFull));

	returnArbiter arbiter (.EXTCLK(EXTCLK), .rstN(rstN),
		.netEmpty(netEmpty), .netBeat(netBeat), .netRd(netRd),
		.streamEmpty(streamEmpty), .streamBeat(streamBeat), .streamRd(streamRd),
		.localDrdy(localDrdy), .localBeat(localBeat), .localRd(localRd),
		.coreDrdy(coreDrdy), .coreBeat(coreBeat));

	//==========================================================================
	// time tick and interrupt handling
	//==========================================================================
	tickGen tick (.EXTCLK(EXTCLK), .rstN(rstN), .tickPulse(tickPulse));

	intSequencer intSeq (.EXTCLK(EXTCLK), .rstN(rstN), .intCtrl(intCtrl),
		.coreState(coreState), .coreStop(coreStop), .msgIntReq(msgIntReq));

endmodule

`default_nettype wire

// ==== hdl/intSequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module intSequencer (
	input  logic                   EXTCLK,
	input  logic                   rstN,
	input  coreSvcPkg::intCtrl_t   intCtrl,
	input  coreSvcPkg::coreState_t coreState,
	output logic                   coreStop,
	output logic                   msgIntReq
);
	logic pendingReg;
	logic intPending;
	logic reqSent;
	logic fire;

	// disabling interrupts drops the pending state right away
	assign intPending = pendingReg & intCtrl.ena;
	assign coreStop = intPending;

	// core drained and not parked on a breakpoint
	assign fire = intPending & coreState.empty & ~coreState.bkpt & ~reqSent;

	always_ff @(posedge EXTCLK or negedge rstN)
	begin
		if (!rstN)
		begin
			pendingReg <= 1'b0;
			reqSent <= 1'b0;
			msgIntReq <= 1'b0;
		end
		else
		begin
			pendingReg <= (intPending | intCtrl.req) & ~intCtrl.ack & intCtrl.ena;
			// one request per pending interval
			reqSent <= (reqSent | fire) & intPending;
			msgIntReq <= fire;
		end
	end

endmodule

`default_nettype wire

// ==== hdl/tickGen.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "coreSvc_cfg.svh"

module tickGen #(
	parameter int scale = `TICK_SCALE
) (
	input  logic EXTCLK,
	input  logic rstN,
	output logic tickPulse
);
	localparam int cntW = $clog2(scale);

	logic [cntW-1:0] cnt;
	logic            lastCycle;

	assign lastCycle = (cnt == cntW'(scale - 1));

	// counter restarts together with each tick
	always_ff @(posedge EXTCLK or negedge rstN)
	begin
		if (!rstN)
		begin
			cnt <= '0;
			tickPulse <= 1'b0;
		end
		else
		begin
			cnt <= lastCycle ? '0 : cnt + 1'b1;
			tickPulse <= lastCycle;
		end
	end

endmodule

`default_nettype wire

// ==== hdl/returnArbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module returnArbiter (
	input  logic                    EXTCLK,
	input  logic                    rstN,
	// network FIFO, highest priority
	input  logic                    netEmpty,
	input  coreSvcPkg::returnBeat_t netBeat,
	output logic                    netRd,
	// stream FIFO
	input  logic                    streamEmpty,
	input  coreSvcPkg::returnBeat_t streamBeat,
	output logic                    streamRd,
	// local memory channel, lowest priority
	input  logic                    localDrdy,
	input  coreSvcPkg::returnBeat_t localBeat,
	output logic                    localRd,
	// toward the core
	output logic                    coreDrdy,
	output coreSvcPkg::returnBeat_t coreBeat
);
	import coreSvcPkg::*;

	returnBeat_t nextBeat;
	logic        anyGrant;

	//==========================================================================
	// fixed priority grant
	//==========================================================================
	assign netRd = ~netEmpty;
	assign streamRd = netEmpty & ~streamEmpty;
	assign localRd = netEmpty & streamEmpty & localDrdy;
	assign anyGrant = netRd | streamRd | localRd;

	always_comb
	begin
		if (netRd)
			nextBeat = netBeat;
		else if (streamRd)
			nextBeat = streamBeat;
		else
			nextBeat = localBeat;
	end

	//==========================================================================
	// output register
	//==========================================================================
	always_ff @(posedge EXTCLK or negedge rstN)
	begin
		if (!rstN)
			coreDrdy <= 1'b0;
		else
			coreDrdy <= anyGrant;
	end

	// data only moves when something was granted
	always_ff @(posedge EXTCLK)
	begin
		if (anyGrant)
			coreBeat <= nextBeat;
	end

endmodule

`default_nettype wire

// ==== hdl/returnFifo.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "coreSvc_cfg.svh"

module returnFifo #(
	parameter int depth = `RETURN_FIFO_DEPTH
) (
	input  logic                    EXTCLK,
	input  logic                    rstN,
	input  logic                    wr,
	input  coreSvcPkg::returnBeat_t wrBeat,
	input  logic                    rd,
	output coreSvcPkg::returnBeat_t rdBeat,
	output logic                    empty,
	output logic                    full
);
	import coreSvcPkg::*;

	localparam int addrW = $clog2(depth);

	returnBeat_t      mem [depth];
	logic [addrW-1:0] wrPtr;
	logic [addrW-1:0] rdPtr;
	logic [addrW:0]   count;
	logic             doWr;
	logic             doRd;

	// writes on full and reads on empty fall through
	assign doWr = wr & ~full;
	assign doRd = rd & ~empty;

	assign empty = (count == '0);
	assign full = (count == (addrW + 1)'(depth));

	// head entry, valid while not empty
	assign rdBeat = mem[rdPtr];

	always_ff @(posedge EXTCLK)
	begin
		if (doWr)
			mem[wrPtr] <= wrBeat;
	end

	// pointers wrap on their own since depth is a power of two
	always_ff @(posedge EXTCLK or negedge rstN)
	begin
		if (!rstN)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end
		else
		begin
			if (doWr)
				wrPtr <= wrPtr + 1'b1;
			if (doRd)
				rdPtr <= rdPtr + 1'b1;
			case ({doWr, doRd})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== hdl/coreSvcPkg.sv ====
`default_nettype none

`include "coreSvc_cfg.svh"

package coreSvcPkg;

	// one returned word with its size code and transaction tag
	typedef struct packed {
		logic [`SIZE_W-1:0] size;
		logic [`TAG_W-1:0]  tag;
		logic [`DATA_W-1:0] data;
	} returnBeat_t;

	// external interrupt controls
	typedef struct packed {
		logic req;
		logic ena;
		logic ack;
	} intCtrl_t;

	// core idle and breakpoint status
	typedef struct packed {
		logic empty;
		logic bkpt;
	} coreState_t;

endpackage

`default_nettype wire

// ==== hdl/coreSvc_cfg.svh ====
`ifndef CORESVC_CFG_SVH
`define CORESVC_CFG_SVH

// return beat fields
`define SIZE_W 3
`define TAG_W 8
`define DATA_W 64

// entries in each return FIFO, power of two
`define RETURN_FIFO_DEPTH 16

// clock cycles between two time ticks
`define TICK_SCALE 20

`endif
